//--- mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address width seen by both requesters and the memory
`define MEM_ADDR_W 20

// one storage line and one data word
`define MEM_LINE_W 128
`define MEM_WORD_W 32

// storage depth in lines, and the index width that addresses them
`define MEM_LINES 4096
`define MEM_LINE_IDX_W 12

`endif

//--- mem_line_pkg.sv
`include "mem_defines.svh"

package mem_line_pkg;

	// size of a data-port write
	typedef enum logic {
		WSIZE_WORD = 1'b0,
		WSIZE_BYTE = 1'b1
	} wsize_e;

	// one full storage line, word lane 0 in the least significant bits
	typedef logic [`MEM_LINE_W-1:0] line_t;

	// selects one of the four words of a line, or one of the four bytes of a word
	typedef logic [1:0] lane_t;

endpackage

//--- mem_arb_pkg.sv
package mem_arb_pkg;

	// current owner of the shared memory port
	typedef enum logic [1:0] {
		SRC_NONE  = 2'd0,
		SRC_FETCH = 2'd1,
		SRC_DATA  = 2'd2
	} req_src_e;

	// idle, or waiting for the read response of the owner
	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_WAIT = 1'b1
	} arb_state_e;

endpackage

//--- line_memory.sv
`timescale 1ns/1ps

`include "mem_defines.svh"

module line_memory (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        mem_read_i,
	input  logic                        mem_write_i,
	input  logic [`MEM_ADDR_W-1:0]      mem_addr_i,
	input  logic [`MEM_WORD_W-1:0]      mem_wdata_i,
	input  mem_line_pkg::wsize_e        mem_wsize_i,
	output logic                        mem_ready_o,
	output mem_line_pkg::line_t         mem_rdata_o,
	output logic [`MEM_ADDR_W-1:0]      mem_raddr_o
);

	localparam int BYTES_PER_LINE = `MEM_LINE_W / 8;

	mem_line_pkg::line_t mem_q [`MEM_LINES];

	logic [`MEM_LINE_IDX_W-1:0] line_idx;
	mem_line_pkg::lane_t        word_lane;
	mem_line_pkg::lane_t        byte_lane;
	logic [BYTES_PER_LINE-1:0]  wr_be;
	mem_line_pkg::line_t        wr_line;

	// bits 3..0 address a byte inside the line, the next bits pick the line
	assign line_idx  = mem_addr_i[`MEM_LINE_IDX_W+3:4];
	assign word_lane = mem_addr_i[3:2];
	assign byte_lane = mem_addr_i[1:0];

	// the write data is replicated across the line, the byte enables pick
	// which copy lands in storage
	always_comb begin
		wr_be   = '0;
		wr_line = {(`MEM_LINE_W / `MEM_WORD_W){mem_wdata_i}};
		case (mem_wsize_i)
			mem_line_pkg::WSIZE_WORD: begin
				wr_be[word_lane*4 +: 4] = 4'hf;
			end
			mem_line_pkg::WSIZE_BYTE: begin
				wr_line                     = {BYTES_PER_LINE{mem_wdata_i[7:0]}};
				wr_be[{word_lane, byte_lane}] = 1'b1;
			end
			default: begin
				wr_be = '0;
			end
		endcase
	end

	// bytes outside the enable mask keep their old value
	always_ff @(posedge clk) begin
		if (mem_write_i) begin
			for (int b = 0; b < BYTES_PER_LINE; b++) begin
				if (wr_be[b]) begin
					mem_q[line_idx][b*8 +: 8] <= wr_line[b*8 +: 8];
				end
			end
		end
	end

	// read response is one registered pulse, with the line and the request address
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mem_ready_o <= 1'b0;
		end else begin
			mem_ready_o <= mem_read_i;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_read_i) begin
			mem_rdata_o <= mem_q[line_idx];
			mem_raddr_o <= mem_addr_i;
		end
	end

	// the arbiter owns the port and must never ask for both at once
	a_no_read_and_write: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!(mem_read_i && mem_write_i)
	) else $error("line_memory: read and write strobed together");

	// a word write must be word aligned, otherwise the low bits would be lost
	a_word_write_aligned: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(mem_write_i && mem_wsize_i == mem_line_pkg::WSIZE_WORD) |-> (mem_addr_i[1:0] == 2'b00)
	) else $error("line_memory: unaligned word write to %h", mem_addr_i);

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_arbiter (
	input  logic                        clk,
	input  logic                        rst_n_i,

	input  logic                        fetch_read_i,
	input  logic [`MEM_ADDR_W-1:0]      fetch_addr_i,
	output logic                        fetch_busy_o,
	output logic                        fetch_ready_o,
	output mem_line_pkg::line_t         fetch_data_o,
	output logic [`MEM_ADDR_W-1:0]      fetch_ready_addr_o,

	input  logic                        data_read_i,
	input  logic                        data_write_i,
	input  logic [`MEM_ADDR_W-1:0]      data_addr_i,
	input  logic [`MEM_WORD_W-1:0]      data_wdata_i,
	input  mem_line_pkg::wsize_e        data_wsize_i,
	output logic                        data_busy_o,
	output logic                        data_ready_o,
	output mem_line_pkg::line_t         data_rdata_o,

	output logic                        mem_read_o,
	output logic                        mem_write_o,
	output logic [`MEM_ADDR_W-1:0]      mem_addr_o,
	output logic [`MEM_WORD_W-1:0]      mem_wdata_o,
	output mem_line_pkg::wsize_e        mem_wsize_o,
	input  logic                        mem_ready_i,
	input  mem_line_pkg::line_t         mem_rdata_i,
	input  logic [`MEM_ADDR_W-1:0]      mem_raddr_i
);

	mem_arb_pkg::arb_state_e state_q;
	mem_arb_pkg::arb_state_e state_d;
	mem_arb_pkg::req_src_e   owner_q;
	mem_arb_pkg::req_src_e   owner_d;

	// fetch slot
	logic                    fetch_valid_q;
	logic [`MEM_ADDR_W-1:0]  fetch_addr_q;

	// data slot
	logic                    data_valid_q;
	logic                    data_is_write_q;
	logic [`MEM_ADDR_W-1:0]  data_addr_q;
	logic [`MEM_WORD_W-1:0]  data_wdata_q;
	mem_line_pkg::wsize_e    data_wsize_q;

	logic                    data_strobe;
	logic                    issue_data;
	logic                    issue_fetch;
	logic                    data_done;

	assign data_strobe = data_read_i || data_write_i;

	// data has fixed priority, and nothing issues while a read is outstanding
	assign issue_data  = (state_q == mem_arb_pkg::ARB_IDLE) && data_valid_q;
	assign issue_fetch = (state_q == mem_arb_pkg::ARB_IDLE) && !data_valid_q && fetch_valid_q;

	assign mem_read_o  = issue_fetch || (issue_data && !data_is_write_q);
	assign mem_write_o = issue_data && data_is_write_q;
	assign mem_addr_o  = issue_data ? data_addr_q : fetch_addr_q;
	assign mem_wdata_o = data_wdata_q;
	assign mem_wsize_o = data_wsize_q;

	// the response goes to whoever issued the outstanding read
	assign fetch_ready_o      = mem_ready_i && (owner_q == mem_arb_pkg::SRC_FETCH);
	assign fetch_data_o       = mem_rdata_i;
	assign fetch_ready_addr_o = mem_raddr_i;
	assign data_ready_o       = mem_ready_i && (owner_q == mem_arb_pkg::SRC_DATA);
	assign data_rdata_o       = mem_rdata_i;

	// a write is finished once issued, a read once its response is back
	assign data_done = (issue_data && data_is_write_q) || data_ready_o;

	// busy drops in the response cycle so the requester may strobe right away
	assign fetch_busy_o = fetch_valid_q && !fetch_ready_o;
	assign data_busy_o  = data_valid_q && !data_ready_o;

	// a new strobe wins over the clear of the previous request
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			fetch_valid_q <= 1'b0;
		end else if (fetch_read_i) begin
			fetch_valid_q <= 1'b1;
		end else if (fetch_ready_o) begin
			fetch_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_read_i) begin
			fetch_addr_q <= fetch_addr_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			data_valid_q <= 1'b0;
		end else if (data_strobe) begin
			data_valid_q <= 1'b1;
		end else if (data_done) begin
			data_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (data_strobe) begin
			data_is_write_q <= data_write_i;
			data_addr_q     <= data_addr_i;
			data_wdata_q    <= data_wdata_i;
			data_wsize_q    <= data_wsize_i;
		end
	end

	always_comb begin
		state_d = state_q;
		owner_d = owner_q;
		case (state_q)
			mem_arb_pkg::ARB_IDLE: begin
				// writes finish in their issue cycle and need no wait
				if (mem_read_o) begin
					state_d = mem_arb_pkg::ARB_WAIT;
					owner_d = issue_data ? mem_arb_pkg::SRC_DATA : mem_arb_pkg::SRC_FETCH;
				end
			end
			mem_arb_pkg::ARB_WAIT: begin
				if (mem_ready_i) begin
					state_d = mem_arb_pkg::ARB_IDLE;
					owner_d = mem_arb_pkg::SRC_NONE;
				end
			end
			default: begin
				state_d = mem_arb_pkg::ARB_IDLE;
				owner_d = mem_arb_pkg::SRC_NONE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= mem_arb_pkg::ARB_IDLE;
			owner_q <= mem_arb_pkg::SRC_NONE;
		end else begin
			state_q <= state_d;
			owner_q <= owner_d;
		end
	end

	// requesters must honour busy, a slot holds a single request
	a_fetch_no_strobe_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!(fetch_read_i && fetch_busy_o)
	) else $error("mem_arbiter: fetch strobe while busy");

	a_data_no_strobe_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!(data_strobe && data_busy_o)
	) else $error("mem_arbiter: data strobe while busy");

	// the memory answers an issued read on the next cycle, and only then
	a_read_answered_next_cycle: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		mem_read_o |=> mem_ready_i
	) else $error("mem_arbiter: read response did not follow the issue");

	a_ready_only_when_waiting: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		mem_ready_i |-> (state_q == mem_arb_pkg::ARB_WAIT)
	) else $error("mem_arbiter: memory response with no read outstanding");

endmodule

//--- mem_subsystem.sv
`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_subsystem (
	input  logic                        clk,
	input  logic                        rst_n_i,

	input  logic                        fetch_read_i,
	input  logic [`MEM_ADDR_W-1:0]      fetch_addr_i,
	output logic                        fetch_busy_o,
	output logic                        fetch_ready_o,
	output mem_line_pkg::line_t         fetch_data_o,
	output logic [`MEM_ADDR_W-1:0]      fetch_ready_addr_o,

	input  logic                        data_read_i,
	input  logic                        data_write_i,
	input  logic [`MEM_ADDR_W-1:0]      data_addr_i,
	input  logic [`MEM_WORD_W-1:0]      data_wdata_i,
	input  mem_line_pkg::wsize_e        data_wsize_i,
	output logic                        data_busy_o,
	output logic                        data_ready_o,
	output mem_line_pkg::line_t         data_rdata_o
);

	// single memory port between the arbiter and the storage
	logic                    mem_read;
	logic                    mem_write;
	logic [`MEM_ADDR_W-1:0]  mem_addr;
	logic [`MEM_WORD_W-1:0]  mem_wdata;
	mem_line_pkg::wsize_e    mem_wsize;
	logic                    mem_ready;
	mem_line_pkg::line_t     mem_rdata;
	logic [`MEM_ADDR_W-1:0]  mem_raddr;

	mem_arbiter u_arbiter (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.fetch_read_i       (fetch_read_i),
		.fetch_addr_i       (fetch_addr_i),
		.fetch_busy_o       (fetch_busy_o),
		.fetch_ready_o      (fetch_ready_o),
		.fetch_data_o       (fetch_data_o),
		.fetch_ready_addr_o (fetch_ready_addr_o),
		.data_read_i        (data_read_i),
		.data_write_i       (data_write_i),
		.data_addr_i        (data_addr_i),
		.data_wdata_i       (data_wdata_i),
		.data_wsize_i       (data_wsize_i),
		.data_busy_o        (data_busy_o),
		.data_ready_o       (data_ready_o),
		.data_rdata_o       (data_rdata_o),
		.mem_read_o         (mem_read),
		.mem_write_o        (mem_write),
		.mem_addr_o         (mem_addr),
		.mem_wdata_o        (mem_wdata),
		.mem_wsize_o        (mem_wsize),
		.mem_ready_i        (mem_ready),
		.mem_rdata_i        (mem_rdata),
		.mem_raddr_i        (mem_raddr)
	);

	line_memory u_memory (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.mem_read_i  (mem_read),
		.mem_write_i (mem_write),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_wsize_i (mem_wsize),
		.mem_ready_o (mem_ready),
		.mem_rdata_o (mem_rdata),
		.mem_raddr_o (mem_raddr)
	);

endmodule

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps

`include "mem_defines.svh"

module tb_mem_subsystem;

	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} data_op_e;

	// one stimulus row holds which ports strobe and what they carry
	typedef struct packed {
		logic                   fetch;
		data_op_e               dop;
		logic [`MEM_ADDR_W-1:0] faddr;
		logic [`MEM_ADDR_W-1:0] daddr;
		logic [`MEM_WORD_W-1:0] wdata;
		mem_line_pkg::wsize_e   wsize;
	} row_t;

	localparam int          MAX_ROWS     = 64;
	localparam int          RESET_CYCLES = 16;
	localparam logic [11:0] LINE_BASE    = 12'h2c0;
	localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

	logic                   clk;
	logic                   rst_n_i;
	logic                   fetch_read_i;
	logic [`MEM_ADDR_W-1:0] fetch_addr_i;
	logic                   fetch_busy_o;
	logic                   fetch_ready_o;
	mem_line_pkg::line_t    fetch_data_o;
	logic [`MEM_ADDR_W-1:0] fetch_ready_addr_o;
	logic                   data_read_i;
	logic                   data_write_i;
	logic [`MEM_ADDR_W-1:0] data_addr_i;
	logic [`MEM_WORD_W-1:0] data_wdata_i;
	mem_line_pkg::wsize_e   data_wsize_i;
	logic                   data_busy_o;
	logic                   data_ready_o;
	mem_line_pkg::line_t    data_rdata_o;

	row_t                   rows [MAX_ROWS];
	int                     n_rows;
	mem_line_pkg::line_t    ref_mem [`MEM_LINES];
	logic [31:0]            lfsr_q;
	int                     cyc;
	int                     cyc_limit;

	mem_subsystem u_dut (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.fetch_read_i       (fetch_read_i),
		.fetch_addr_i       (fetch_addr_i),
		.fetch_busy_o       (fetch_busy_o),
		.fetch_ready_o      (fetch_ready_o),
		.fetch_data_o       (fetch_data_o),
		.fetch_ready_addr_o (fetch_ready_addr_o),
		.data_read_i        (data_read_i),
		.data_write_i       (data_write_i),
		.data_addr_i        (data_addr_i),
		.data_wdata_i       (data_wdata_i),
		.data_wsize_i       (data_wsize_i),
		.data_busy_o        (data_busy_o),
		.data_ready_o       (data_ready_o),
		.data_rdata_o       (data_rdata_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (cyc_limit > 0 && cyc >= cyc_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cyc_limit);
			$display("Errors found");
			$fatal(1, "simulation stopped by the cycle limit");
		end else begin
			cyc <= cyc + 1;
		end
	end

	// galois LFSR stepped once per bit taken, with the newest bit in the lsb
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
		end
		return v;
	endfunction

	function automatic logic [1:0] rand2();
		logic [31:0] v;
		v = take_bits(2);
		return v[1:0];
	endfunction

	// the upper bits are random since only bits 15..4 pick the line
	function automatic logic [`MEM_ADDR_W-1:0] make_addr(input logic [1:0] line_sel,
			input logic [1:0] word_sel, input logic [1:0] byte_sel);
		logic [31:0] upper;
		logic [11:0] idx;
		upper = take_bits(4);
		idx   = LINE_BASE + {10'd0, line_sel};
		return {upper[3:0], idx, word_sel, byte_sel};
	endfunction

	function automatic void ref_write(input logic [`MEM_ADDR_W-1:0] addr,
			input logic [`MEM_WORD_W-1:0] wdata, input mem_line_pkg::wsize_e wsize);
		logic [11:0] line_idx;
		int          bit_off;
		line_idx = addr[15:4];
		if (wsize == mem_line_pkg::WSIZE_WORD) begin
			bit_off = 32 * int'(addr[3:2]);
			ref_mem[line_idx][bit_off +: 32] = wdata;
		end else begin
			bit_off = 32 * int'(addr[3:2]) + 8 * int'(addr[1:0]);
			ref_mem[line_idx][bit_off +: 8] = wdata[7:0];
		end
	endfunction

	task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic add_row(input logic fetch, input data_op_e dop,
			input logic [`MEM_ADDR_W-1:0] faddr, input logic [`MEM_ADDR_W-1:0] daddr,
			input logic [`MEM_WORD_W-1:0] wdata, input mem_line_pkg::wsize_e wsize);
		rows[n_rows].fetch = fetch;
		rows[n_rows].dop   = dop;
		rows[n_rows].faddr = faddr;
		rows[n_rows].daddr = daddr;
		rows[n_rows].wdata = wdata;
		rows[n_rows].wsize = wsize;
		n_rows++;
	endtask

	task automatic build_table();
		logic [1:0]           l;
		logic [1:0]           w;
		logic [1:0]           b;
		logic [31:0]          v;
		logic [31:0]          wd;
		logic                 f;
		logic [`MEM_ADDR_W-1:0] fa;
		logic [`MEM_ADDR_W-1:0] da;
		data_op_e             op;
		mem_line_pkg::wsize_e sz;
		// storage has no reset, so every word of the test lines is written first
		for (int li = 0; li < 4; li++) begin
			for (int wi = 0; wi < 4; wi++) begin
				wd = take_bits(32);
				da = make_addr(2'(li), 2'(wi), 2'b00);
				add_row(1'b0, OP_WRITE, '0, da, wd, mem_line_pkg::WSIZE_WORD);
			end
		end
		// lone fetch reads, one per line
		for (int li = 0; li < 4; li++) begin
			w  = rand2();
			b  = rand2();
			fa = make_addr(2'(li), w, b);
			add_row(1'b1, OP_NONE, fa, '0, '0, mem_line_pkg::WSIZE_WORD);
		end
		// word write, then a data read of the same line
		for (int k = 0; k < 4; k++) begin
			l  = rand2();
			w  = rand2();
			wd = take_bits(32);
			add_row(1'b0, OP_WRITE, '0, make_addr(l, w, 2'b00), wd, mem_line_pkg::WSIZE_WORD);
			w  = rand2();
			add_row(1'b0, OP_READ, '0, make_addr(l, w, 2'b00), '0, mem_line_pkg::WSIZE_WORD);
		end
		// byte write to each byte lane in turn, then read it back
		for (int k = 0; k < 4; k++) begin
			l  = rand2();
			w  = rand2();
			wd = take_bits(32);
			add_row(1'b0, OP_WRITE, '0, make_addr(l, w, 2'(k)), wd, mem_line_pkg::WSIZE_BYTE);
			add_row(1'b0, OP_READ, '0, make_addr(l, w, 2'b00), '0, mem_line_pkg::WSIZE_WORD);
		end
		// fetch and data reads together
		for (int k = 0; k < 4; k++) begin
			l  = rand2();
			fa = make_addr(l, 2'b01, 2'b10);
			l  = rand2();
			da = make_addr(l, 2'b11, 2'b00);
			add_row(1'b1, OP_READ, fa, da, '0, mem_line_pkg::WSIZE_WORD);
		end
		// data write and fetch read of the same line together
		for (int k = 0; k < 4; k++) begin
			l  = rand2();
			w  = rand2();
			b  = rand2();
			wd = take_bits(32);
			sz = k[0] ? mem_line_pkg::WSIZE_BYTE : mem_line_pkg::WSIZE_WORD;
			da = make_addr(l, w, (sz == mem_line_pkg::WSIZE_BYTE) ? b : 2'b00);
			fa = make_addr(l, 2'b00, 2'b00);
			add_row(1'b1, OP_WRITE, fa, da, wd, sz);
		end
		// random mix over the same few lines
		for (int k = 0; k < 12; k++) begin
			v  = take_bits(1);
			f  = v[0];
			b  = rand2();
			op = (b == 2'd2) ? OP_WRITE : ((b == 2'd0 && f) ? OP_NONE : OP_READ);
			v  = take_bits(1);
			sz = v[0] ? mem_line_pkg::WSIZE_BYTE : mem_line_pkg::WSIZE_WORD;
			l  = rand2();
			w  = rand2();
			b  = (sz == mem_line_pkg::WSIZE_BYTE) ? rand2() : 2'b00;
			da = make_addr(l, w, b);
			l  = rand2();
			w  = rand2();
			fa = make_addr(l, w, 2'b00);
			wd = take_bits(32);
			add_row(f, op, fa, da, wd, sz);
		end
	endtask

	task automatic run_row(input row_t r);
		mem_line_pkg::line_t exp_fetch;
		mem_line_pkg::line_t exp_data;
		logic                want_fetch;
		logic                want_data;
		logic                got_fetch;
		logic                got_data;
		logic                first;
		logic                done;
		int                  start;
		int                  fetch_cyc;
		int                  data_cyc;
		want_fetch = r.fetch;
		want_data  = (r.dop == OP_READ);
		got_fetch  = 1'b0;
		got_data   = 1'b0;
		first      = 1'b1;
		done       = 1'b0;
		fetch_cyc  = 0;
		data_cyc   = 0;
		@(posedge clk);
		#0.5;
		fetch_read_i = r.fetch;
		fetch_addr_i = r.faddr;
		data_read_i  = want_data;
		data_write_i = (r.dop == OP_WRITE);
		data_addr_i  = r.daddr;
		data_wdata_i = r.wdata;
		data_wsize_i = r.wsize;
		start = cyc;
		// the data slot issues first, so a fetch in the same row sees the write
		if (r.dop == OP_WRITE) begin
			ref_write(r.daddr, r.wdata, r.wsize);
		end
		exp_fetch = ref_mem[r.faddr[15:4]];
		exp_data  = ref_mem[r.daddr[15:4]];
		@(posedge clk);
		#0.5;
		fetch_read_i = 1'b0;
		data_read_i  = 1'b0;
		data_write_i = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (first) begin
				compare("fetch_busy_o", 128'(fetch_busy_o), 128'(r.fetch));
				compare("data_busy_o", 128'(data_busy_o), 128'(r.dop != OP_NONE));
				first = 1'b0;
			end
			if (fetch_ready_o) begin
				if (!want_fetch || got_fetch) begin
					report_failure("fetch_ready_o pulsed with no fetch read outstanding");
				end
				compare("fetch_data_o", fetch_data_o, exp_fetch);
				compare("fetch_ready_addr_o", 128'(fetch_ready_addr_o), 128'(r.faddr));
				got_fetch = 1'b1;
				fetch_cyc = cyc - start;
			end
			if (data_ready_o) begin
				if (!want_data || got_data) begin
					report_failure("data_ready_o pulsed with no data read outstanding");
				end
				compare("data_rdata_o", data_rdata_o, exp_data);
				got_data = 1'b1;
				data_cyc = cyc - start;
			end
			done = (got_fetch == want_fetch) && (got_data == want_data) &&
				!fetch_busy_o && !data_busy_o;
		end
		@(negedge clk);
		compare("fetch_ready_o", 128'(fetch_ready_o), 128'(0));
		compare("data_ready_o", 128'(data_ready_o), 128'(0));
		if (want_fetch && r.dop == OP_NONE) begin
			compare("fetch latency", 128'(fetch_cyc), 128'(2));
		end
		if (want_data) begin
			compare("data latency", 128'(data_cyc), 128'(2));
		end
		if (want_fetch && want_data && data_cyc >= fetch_cyc) begin
			report_failure("data_ready_o did not arrive before fetch_ready_o");
		end
		// the write takes one issue cycle ahead of the fetch
		if (want_fetch && r.dop == OP_WRITE) begin
			compare("fetch latency", 128'(fetch_cyc), 128'(3));
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst_n_i      = 1'b0;
		fetch_read_i = 1'b0;
		fetch_addr_i = '0;
		data_read_i  = 1'b0;
		data_write_i = 1'b0;
		data_addr_i  = '0;
		data_wdata_i = '0;
		data_wsize_i = mem_line_pkg::WSIZE_WORD;
		lfsr_q       = 32'h47e2_b3b8;
		n_rows       = 0;
		cyc          = 0;
		cyc_limit    = 0;
		build_table();
		cyc_limit = 20 * n_rows + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5;
		rst_n_i = 1'b1;
		@(negedge clk);
		compare("fetch_ready_o", 128'(fetch_ready_o), 128'(0));
		compare("fetch_busy_o", 128'(fetch_busy_o), 128'(0));
		compare("data_ready_o", 128'(data_ready_o), 128'(0));
		compare("data_busy_o", 128'(data_busy_o), 128'(0));
		compare("mem_read_o", 128'(u_dut.mem_read), 128'(0));
		compare("mem_write_o", 128'(u_dut.mem_write), 128'(0));
		for (int i = 0; i < n_rows; i++) begin
			run_row(rows[i]);
		end
		$display("No errors");
		$finish;
	end

endmodule

//--- all.f
+incdir+.
mem_line_pkg.sv
mem_arb_pkg.sv
line_memory.sv
mem_arbiter.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Compiles the memory subsystem testbench with Verilator and runs it.
# The result is decided by searching the simulation log.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_mem_subsystem \
	-Mdir "$BUILD_DIR" \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "No errors" "$LOG"; then
	echo "simulation ended without a pass report"
	exit 1
fi

echo "simulation passed"
exit 0
